// ==== verilog/mem_bus_pkg.sv ====
package mem_bus_pkg;

  // commands the cache may put on the instruction memory bus
  typedef enum logic [1:0] {
    bus_none = 2'b00,  // idle
    bus_load = 2'b01   // fetch one 8-byte line
  } bus_cmd_t;

  // transaction number handed out by memory on acceptance
  typedef logic [3:0] mem_tag_t;

  // byte address on the bus
  typedef logic [15:0] mem_addr_t;

  // one memory line, two instructions wide
  typedef logic [63:0] mem_data_t;

  // response / return tag of zero means nothing happened
  localparam mem_tag_t TAG_NONE = 4'd0;

  // live transaction numbers run first..last then wrap
  localparam mem_tag_t TAG_FIRST = 4'd1;
  localparam mem_tag_t TAG_LAST  = 4'd15;

endpackage

// ==== verilog/icache_pkg.sv ====
package icache_pkg;

  // byte address without the offset inside a line
  typedef logic [12:0] line_addr_t;

  // one instruction word
  typedef logic [31:0] inst_t;

  localparam int NUM_LINES      = 32;  // default cache size in lines
  localparam int PREFETCH_DEPTH = 8;   // default lines ahead of fetch

  localparam int LINE_OFFSET_W = 3;    // 8 bytes per line

  // strip the byte offset
  function automatic line_addr_t line_of(input mem_bus_pkg::mem_addr_t addr);
    return addr[$bits(mem_bus_pkg::mem_addr_t)-1:LINE_OFFSET_W];
  endfunction

  // first byte of a line
  function automatic mem_bus_pkg::mem_addr_t addr_of_line(input line_addr_t line);
    return {line, {LINE_OFFSET_W{1'b0}}};
  endfunction

  // low word sits at the lower address, bit 2 picks the half
  function automatic inst_t inst_of(input mem_bus_pkg::mem_data_t line,
                                    input mem_bus_pkg::mem_addr_t  addr);
    return addr[2] ? line[63:32] : line[31:0];
  endfunction

endpackage

// ==== verilog/icache.sv ====
`timescale 1ns/1ps

module icache #(
  parameter int NUM_LINES      = icache_pkg::NUM_LINES,
  parameter int PREFETCH_DEPTH = icache_pkg::PREFETCH_DEPTH
) (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  mem_bus_pkg::mem_addr_t i_fetch_addr,    // pc from fetch stage
  output mem_bus_pkg::mem_data_t o_line,          // whole line, fetch picks the word
  output logic                   o_hit,           // valid and tag match
  output mem_bus_pkg::bus_cmd_t  o_mem_cmd,
  output mem_bus_pkg::mem_addr_t o_mem_addr,
  input  mem_bus_pkg::mem_tag_t  i_mem_response,  // 0 when denied
  input  mem_bus_pkg::mem_tag_t  i_mem_tag,       // 0 when nothing returns
  input  mem_bus_pkg::mem_data_t i_mem_data
);
  import mem_bus_pkg::*;
  import icache_pkg::*;

  localparam int LINE_W = $bits(line_addr_t);
  localparam int IDX_W  = $clog2(NUM_LINES);
  localparam int TAG_W  = LINE_W - IDX_W;
  localparam int NUM_TAGS = int'(TAG_LAST);
  // window kept below the cache size so a prefetch never evicts a line still ahead
  localparam int PF_WINDOW = (PREFETCH_DEPTH < NUM_LINES) ? PREFETCH_DEPTH : NUM_LINES - 1;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] ctag_t;

  // per-line state
  logic [NUM_LINES-1:0] line_valid;
  logic [NUM_LINES-1:0] line_req;     // load in flight for this index
  ctag_t                line_tag  [NUM_LINES];
  mem_data_t            line_data [NUM_LINES];

  // outstanding loads, indexed by transaction number
  logic [NUM_TAGS:1] tt_pending;
  idx_t              tt_idx [1:NUM_TAGS];

  line_addr_t pf_ptr;         // line last put on the bus (or scanned)
  logic       retry_pending;  // last cycle's load was denied
  line_addr_t retry_line;     // and this is what it asked for

  line_addr_t fetch_line;
  line_addr_t ptr_dist;
  line_addr_t pf_line;
  line_addr_t req_line;
  idx_t       f_idx;
  idx_t       pf_idx;
  idx_t       req_idx;
  logic       demand_miss;
  logic       pf_present;
  logic       pf_issue;
  logic       accepted;
  logic       fill;

  function automatic idx_t idx_of(input line_addr_t line);
    return line[IDX_W-1:0];
  endfunction

  function automatic ctag_t tag_of(input line_addr_t line);
    return line[LINE_W-1:IDX_W];
  endfunction

  // fetch side lookup, zero latency
  assign fetch_line = line_of(i_fetch_addr);
  assign f_idx      = idx_of(fetch_line);
  assign o_line     = line_data[f_idx];
  assign o_hit      = line_valid[f_idx] && (line_tag[f_idx] == tag_of(fetch_line));

  // a miss waits if its index already has a load out
  assign demand_miss = !o_hit && !line_req[f_idx];

  // next prefetch candidate, restart right after fetch line once out of window
  assign ptr_dist = pf_ptr - fetch_line;  // wraps, so behind fetch reads as far
  assign pf_line  = (ptr_dist < line_addr_t'(PF_WINDOW)) ? pf_ptr + line_addr_t'(1)
                                                          : fetch_line + line_addr_t'(1);
  assign pf_idx     = idx_of(pf_line);
  assign pf_present = line_valid[pf_idx] && (line_tag[pf_idx] == tag_of(pf_line));
  assign pf_issue   = !pf_present && !line_req[pf_idx];

  // bus priority is demand, then retry, then prefetch
  always_comb begin
    o_mem_cmd = bus_load;
    req_line  = fetch_line;
    if (demand_miss) begin
      req_line = fetch_line;
    end else if (retry_pending) begin
      req_line = retry_line;  // same address as the denied one
    end else if (pf_issue) begin
      req_line = pf_line;
    end else begin
      o_mem_cmd = bus_none;
      req_line  = pf_line;    // nothing to load, scan pointer still steps
    end
  end

  assign o_mem_addr = addr_of_line(req_line);
  assign req_idx    = idx_of(req_line);

  assign accepted = (i_mem_response != TAG_NONE);
  assign fill     = (i_mem_tag != TAG_NONE) && tt_pending[i_mem_tag];

  // control state
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      line_valid    <= '0;
      line_req      <= '0;
      tt_pending    <= '0;
      pf_ptr        <= '0;
      retry_pending <= 1'b0;
    end else begin
      pf_ptr        <= req_line;
      retry_pending <= (o_mem_cmd == bus_load) && !accepted;
      if (fill) begin
        line_valid[tt_idx[i_mem_tag]] <= 1'b1;
        line_req[tt_idx[i_mem_tag]]   <= 1'b0;
        tt_pending[i_mem_tag]         <= 1'b0;
      end
      // accepted index never has a load out, so no clash with the fill above
      if (accepted) begin
        line_valid[req_idx]        <= 1'b0;  // evict old contents
        line_req[req_idx]          <= 1'b1;
        tt_pending[i_mem_response] <= 1'b1;
      end
    end
  end

  // payload
  always_ff @(posedge i_clock) begin
    retry_line <= req_line;
    if (fill) begin
      line_data[tt_idx[i_mem_tag]] <= i_mem_data;
    end
    if (accepted) begin
      line_tag[req_idx]      <= tag_of(req_line);
      tt_idx[i_mem_response] <= req_idx;  // index of the address actually sent
    end
  end

  // memory only returns what it accepted earlier and we still wait for
  a_tag_pending : assert property (@(posedge i_clock) disable iff (i_reset)
    (i_mem_tag != TAG_NONE) |-> tt_pending[i_mem_tag]);

  // memory never hands out a transaction without a load
  a_idle_no_response : assert property (@(posedge i_clock) disable iff (i_reset)
    (o_mem_cmd == bus_none) |-> (i_mem_response == TAG_NONE));

endmodule

// ==== verilog/tagged_imem.sv ====
`timescale 1ns/1ps

module tagged_imem #(
  parameter int MEM_LATENCY = 6
) (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  mem_bus_pkg::bus_cmd_t  i_cmd,
  input  mem_bus_pkg::mem_addr_t i_addr,
  output mem_bus_pkg::mem_tag_t  o_response,      // transaction number or 0
  output mem_bus_pkg::mem_tag_t  o_tag,           // returning transaction or 0
  output mem_bus_pkg::mem_data_t o_data,
  input  logic                   i_busy,          // deny everything
  input  logic                   i_preload_en,
  input  icache_pkg::line_addr_t i_preload_addr,
  input  mem_bus_pkg::mem_data_t i_preload_data
);
  import mem_bus_pkg::*;
  import icache_pkg::*;

  localparam int MEM_WORDS = 8192;  // whole 16-bit space in lines

  mem_data_t  mem [MEM_WORDS];
  mem_tag_t   tag_count;                // number for the next accepted load
  mem_tag_t   pipe_tag  [MEM_LATENCY];  // in-flight loads, oldest last
  line_addr_t pipe_line [MEM_LATENCY];
  logic       accept;

  // preload owns the array, so loads wait
  assign accept     = (i_cmd == bus_load) && !i_busy && !i_preload_en;
  assign o_response = accept ? tag_count : TAG_NONE;

  // last stage is MEM_LATENCY cycles after acceptance
  assign o_tag  = pipe_tag[MEM_LATENCY-1];
  assign o_data = mem[pipe_line[MEM_LATENCY-1]];  // read at return time

  // preload port
  always_ff @(posedge i_clock) begin
    if (i_preload_en) begin
      mem[i_preload_addr] <= i_preload_data;
    end
  end

  // rotating transaction number, skips 0
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      tag_count <= TAG_FIRST;
    end else if (accept) begin
      tag_count <= (tag_count == TAG_LAST) ? TAG_FIRST : tag_count + mem_tag_t'(1);
    end
  end

  // return pipeline, tags
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int k = 0; k < MEM_LATENCY; k++) begin
        pipe_tag[k] <= TAG_NONE;
      end
    end else begin
      pipe_tag[0] <= o_response;  // empty slot when denied or idle
      for (int k = 1; k < MEM_LATENCY; k++) begin
        pipe_tag[k] <= pipe_tag[k-1];
      end
    end
  end

  // return pipeline, addresses
  always_ff @(posedge i_clock) begin
    pipe_line[0] <= line_of(i_addr);
    for (int k = 1; k < MEM_LATENCY; k++) begin
      pipe_line[k] <= pipe_line[k-1];
    end
  end

  // no load slips in while the image is written
  a_preload_excl : assert property (@(posedge i_clock) disable iff (i_reset)
    i_preload_en |-> (o_response == TAG_NONE));

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
  parameter mem_bus_pkg::mem_addr_t RESET_PC = '0
) (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic                   i_redirect,     // strobe, target taken at next edge
  input  mem_bus_pkg::mem_addr_t i_redirect_pc,
  input  logic                   i_stall,
  input  mem_bus_pkg::mem_data_t i_line,         // line from cache for o_fetch_addr
  input  logic                   i_hit,
  output mem_bus_pkg::mem_addr_t o_fetch_addr,
  output icache_pkg::inst_t      o_inst,
  output mem_bus_pkg::mem_addr_t o_inst_pc,
  output logic                   o_inst_valid
);
  import mem_bus_pkg::*;
  import icache_pkg::*;

  localparam mem_addr_t INST_BYTES = 16'd4;

  mem_addr_t pc;

  assign o_fetch_addr = pc;
  assign o_inst       = inst_of(i_line, pc);  // bit 2 picks the half
  assign o_inst_pc    = pc;
  // old path is dropped in the redirect cycle
  assign o_inst_valid = i_hit && !i_stall && !i_redirect;

  // redirect beats advance, miss or stall holds pc
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      pc <= RESET_PC;
    end else if (i_redirect) begin
      pc <= i_redirect_pc;
    end else if (i_hit && !i_stall) begin
      pc <= pc + INST_BYTES;
    end
  end

  // reset value and every redirect target keep word alignment
  a_pc_aligned : assert property (@(posedge i_clock) disable iff (i_reset)
    pc[1:0] == 2'b00);

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
  parameter int                     NUM_LINES      = icache_pkg::NUM_LINES,
  parameter int                     PREFETCH_DEPTH = icache_pkg::PREFETCH_DEPTH,
  parameter int                     MEM_LATENCY    = 6,   // keep below 15
  parameter mem_bus_pkg::mem_addr_t RESET_PC       = '0
) (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic                   i_redirect,
  input  mem_bus_pkg::mem_addr_t i_redirect_pc,
  input  logic                   i_stall,
  input  logic                   i_mem_busy,
  input  logic                   i_preload_en,
  input  icache_pkg::line_addr_t i_preload_addr,
  input  mem_bus_pkg::mem_data_t i_preload_data,
  output icache_pkg::inst_t      o_inst,
  output mem_bus_pkg::mem_addr_t o_inst_pc,
  output logic                   o_inst_valid
);
  import mem_bus_pkg::*;

  mem_addr_t fetch_addr;
  mem_data_t cache_line;
  logic      cache_hit;
  bus_cmd_t  mem_cmd;
  mem_addr_t mem_addr;
  mem_tag_t  mem_response;
  mem_tag_t  mem_tag;
  mem_data_t mem_data;

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .i_clock(i_clock),
    .i_reset(i_reset),
    .i_redirect(i_redirect),
    .i_redirect_pc(i_redirect_pc),
    .i_stall(i_stall),
    .i_line(cache_line),
    .i_hit(cache_hit),
    .o_fetch_addr(fetch_addr),
    .o_inst(o_inst),
    .o_inst_pc(o_inst_pc),
    .o_inst_valid(o_inst_valid)
  );

  icache #(
    .NUM_LINES(NUM_LINES),
    .PREFETCH_DEPTH(PREFETCH_DEPTH)
  ) u_icache (
    .i_clock(i_clock),
    .i_reset(i_reset),
    .i_fetch_addr(fetch_addr),
    .o_line(cache_line),
    .o_hit(cache_hit),
    .o_mem_cmd(mem_cmd),
    .o_mem_addr(mem_addr),
    .i_mem_response(mem_response),
    .i_mem_tag(mem_tag),
    .i_mem_data(mem_data)
  );

  tagged_imem #(
    .MEM_LATENCY(MEM_LATENCY)
  ) u_imem (
    .i_clock(i_clock),
    .i_reset(i_reset),
    .i_cmd(mem_cmd),
    .i_addr(mem_addr),
    .o_response(mem_response),
    .o_tag(mem_tag),
    .o_data(mem_data),
    .i_busy(i_mem_busy),
    .i_preload_en(i_preload_en),
    .i_preload_addr(i_preload_addr),
    .i_preload_data(i_preload_data)
  );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 4
) (
  output logic o_clock
);
  initial begin
    o_clock = 1'b0;
  end
  always #(PERIOD_NS / 2) o_clock = ~o_clock;  // 50% duty
endmodule

// ==== verification/tb_fetch_checker.sv ====
`timescale 1ns/1ps

module tb_fetch_checker #(
  parameter int                     STREAM_LEN = 16,
  parameter mem_bus_pkg::mem_addr_t RESET_PC   = '0
) (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  logic                   i_preload_en,
  input  icache_pkg::line_addr_t i_preload_addr,
  input  mem_bus_pkg::mem_data_t i_preload_data,
  input  logic                   i_redirect,
  input  mem_bus_pkg::mem_addr_t i_redirect_pc,
  input  logic                   i_stall,
  input  logic                   i_mem_busy,
  input  icache_pkg::inst_t      i_inst,
  input  mem_bus_pkg::mem_addr_t i_inst_pc,
  input  logic                   i_inst_valid,
  input  logic [2:0]             i_expect,      // stream, cold target, hit after redirect
  output int                     o_scen_count,  // deliveries since last redirect
  output int                     o_errors
);
  import mem_bus_pkg::*;
  import icache_pkg::*;

  mem_data_t image [8192];  // own copy of the preloaded lines
  bit        known [8192];
  mem_addr_t exp_pc = RESET_PC;
  logic      fresh = 1'b0;  // redirect seen, first unstalled cycle pending
  int        run_left = 0;  // stream cycles still owed
  int        scen_count = 0;
  int        errors = 0;
  inst_t     want;

  assign o_scen_count = scen_count;
  assign o_errors     = errors;

  task automatic report_err(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // sampled at the edge, so every value is the settled one of the cycle just ended
  always @(posedge i_clock) begin
    if (i_preload_en) begin
      image[i_preload_addr] = i_preload_data;
      known[i_preload_addr] = 1'b1;
    end
    if (i_reset) begin
      exp_pc = RESET_PC;
      fresh = 1'b0;
      run_left = 0;
    end else begin
      if (i_inst_valid) begin
        if (!known[i_inst_pc[15:3]]) begin
          report_err($sformatf("pc %h is outside the preloaded image", i_inst_pc));
        end else begin
          want = i_inst_pc[2] ? image[i_inst_pc[15:3]][63:32] : image[i_inst_pc[15:3]][31:0];
          if (i_inst !== want) begin
            report_err($sformatf("pc %h gave %h, image holds %h", i_inst_pc, i_inst, want));
          end
        end
        if (i_inst_pc !== exp_pc) begin
          report_err($sformatf("pc %h delivered, %h expected", i_inst_pc, exp_pc));
        end
        if (i_redirect) begin
          report_err($sformatf("pc %h delivered in the redirect cycle", i_inst_pc));
        end
        if (i_mem_busy && i_expect[1]) begin
          report_err($sformatf("pc %h delivered while memory busy", i_inst_pc));
        end
        exp_pc = i_inst_pc + 16'd4;  // resync so one slip gives one error
        scen_count++;
      end
      if (i_redirect) begin
        exp_pc = i_redirect_pc;  // old path ends here
        fresh = 1'b1;
        run_left = 0;
        scen_count = 0;
      end else if (fresh && !i_stall) begin
        fresh = 1'b0;
        if (i_expect[0] && !i_inst_valid) begin
          report_err($sformatf("no hit in first cycle at pc %h", exp_pc));
        end
        if (i_expect[2]) begin
          run_left = STREAM_LEN;  // prefetched lines back to back
        end
      end
      if (run_left > 0 && !i_redirect) begin
        run_left--;
        if (!i_inst_valid) begin
          report_err($sformatf("gap in prefetch stream at pc %h", exp_pc));
          run_left = 0;
        end
      end
    end
  end
endmodule

// ==== verification/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;
  import mem_bus_pkg::*;
  import icache_pkg::*;

  localparam int PREFETCH_DEPTH = 8;
  localparam int MAX_RECS       = 32;
  localparam int WAIT_LIMIT     = 3000;  // cycles per scenario

  logic        clock;
  logic        reset;
  logic        redirect;
  mem_addr_t   redirect_pc;
  logic        stall;
  logic        mem_busy;
  logic        preload_en;
  line_addr_t  preload_addr;
  mem_data_t   preload_data;
  inst_t       inst;
  mem_addr_t   inst_pc;
  logic        inst_valid;
  logic [2:0]  expect_flags;
  int          scen_count;
  int          value_errors;
  int          timeouts = 0;
  int          setup_errors = 0;
  int          scenarios = 0;
  int          stall_left = 0;
  int          busy_left = 0;
  logic        random_stall = 1'b0;
  logic [31:0] rnd = 32'hc32eb983;
  logic [99:0] recs [MAX_RECS];  // kind, a, b, c

  tb_clock #(.PERIOD_NS(4)) u_clock (.o_clock(clock));

  fetch_top #(
    .NUM_LINES(32),
    .PREFETCH_DEPTH(PREFETCH_DEPTH),
    .MEM_LATENCY(6),
    .RESET_PC(16'h0000)
  ) i_fetch_top (
    .i_clock(clock), .i_reset(reset),
    .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .i_stall(stall), .i_mem_busy(mem_busy),
    .i_preload_en(preload_en), .i_preload_addr(preload_addr), .i_preload_data(preload_data),
    .o_inst(inst), .o_inst_pc(inst_pc), .o_inst_valid(inst_valid)
  );

  tb_fetch_checker #(
    .STREAM_LEN(2 * PREFETCH_DEPTH),
    .RESET_PC(16'h0000)
  ) u_checker (
    .i_clock(clock), .i_reset(reset),
    .i_preload_en(preload_en), .i_preload_addr(preload_addr), .i_preload_data(preload_data),
    .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .i_stall(stall), .i_mem_busy(mem_busy),
    .i_inst(inst), .i_inst_pc(inst_pc), .i_inst_valid(inst_valid),
    .i_expect(expect_flags), .o_scen_count(scen_count), .o_errors(value_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // every field of the pattern carries the full line address
  function automatic mem_data_t image_line(input mem_data_t base, input line_addr_t line);
    return base ^ {line, 3'b000, ~line, 3'b000, line ^ 13'h1555, 3'b000, line, 3'b101};
  endfunction

  // one cycle of stall and busy, counted down
  task automatic drive_controls();
    rnd = xorshift32(rnd);
    stall <= (stall_left > 0) || (random_stall && rnd[1:0] == 2'b00);
    mem_busy <= (busy_left > 0);
    if (stall_left > 0) begin
      stall_left--;
    end
    if (busy_left > 0) begin
      busy_left--;
    end
  endtask

  task automatic preload_run(input line_addr_t first, input int count, input mem_data_t base);
    line_addr_t line;
    for (int k = 0; k < count; k++) begin
      line = first + line_addr_t'(k);
      @(posedge clock);
      preload_en <= 1'b1;
      preload_addr <= line;
      preload_data <= image_line(base, line);
    end
  endtask

  // ctrl is stall cycles, busy cycles, flags
  task automatic run_scenario(input mem_addr_t target, input int count, input logic [47:0] ctrl);
    int   waited;
    logic done;
    waited = 0;
    done = 1'b0;
    stall_left = int'(ctrl[47:32]);
    busy_left = int'(ctrl[31:16]);
    random_stall = ctrl[3];
    @(posedge clock);
    redirect <= 1'b1;
    redirect_pc <= target;
    expect_flags <= ctrl[2:0];
    drive_controls();
    @(posedge clock);
    redirect <= 1'b0;
    drive_controls();
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge clock);  // checker count settled by now
      if (scen_count >= count) begin
        done = 1'b1;
      end else begin
        @(posedge clock);
        drive_controls();
        waited++;
      end
    end
    if (!done) begin
      $display("timeout: scenario %0d at pc %h delivered %0d of %0d instructions",
               scenarios, target, scen_count, count);
      timeouts++;
    end
  endtask

  initial begin
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    stall = 1'b0;
    mem_busy = 1'b0;
    preload_en = 1'b0;
    preload_addr = '0;
    preload_data = '0;
    expect_flags = 3'b000;
    for (int k = 0; k < MAX_RECS; k++) begin
      recs[k] = '0;
    end
    $readmemh("verification/fetch_cases.txt", recs);
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int k = 0; k < MAX_RECS; k++) begin
      if (recs[k][99:96] == 4'h1) begin
        preload_run(recs[k][92:80], int'(recs[k][79:64]), recs[k][63:0]);
      end
    end
    @(posedge clock);
    preload_en <= 1'b0;
    for (int k = 0; k < MAX_RECS; k++) begin
      if (recs[k][99:96] == 4'h2 && timeouts == 0) begin
        scenarios++;
        run_scenario(recs[k][95:80], int'(recs[k][79:64]), recs[k][63:16]);
      end
    end
    if (scenarios == 0) begin
      $display("no scenario records found in verification/fetch_cases.txt");
      setup_errors++;
    end
    @(negedge clock);
    $display("closing: %0d scenarios, %0d value errors, %0d timeouts, %0d setup errors",
             scenarios, value_errors, timeouts, setup_errors);
    if (value_errors == 0 && timeouts == 0 && setup_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end
endmodule

// ==== verification/fetch_cases.txt ====
// kind_a_b_c, kind 1 image run: a first line, b line count, c base data
// kind 2 scenario: a target pc, b instructions, c stall_busy_flags_unused
// flags bit0 hit after redirect, bit1 cold under busy, bit2 stream, bit3 random stall
1_0000_0060_13579bdf02468ace
1_0400_0040_a5a5f00d3c3c0ff0
2_0000_0018_0000_0000_0000_0000
2_0010_0004_0000_0000_0001_0000
2_2004_000a_0000_0014_0002_0000
2_0100_0014_0046_0000_0004_0000
2_2100_0028_0000_0000_0008_0000
2_0200_001e_0000_000a_000a_0000
2_0204_0006_0000_0000_0001_0000

// ==== filelist.f ====
verilog/mem_bus_pkg.sv
verilog/icache_pkg.sv
verilog/icache.sv
verilog/tagged_imem.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
verification/tb_clock.sv
verification/tb_fetch_checker.sv
verification/tb_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch -f filelist.f -o tb_fetch_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
